//--- fir_ctrl_pkg.sv
package fir_ctrl_pkg;

	////////////////////////////////////////////////////////////
	// axi-lite bus widths
	////////////////////////////////////////////////////////////

	typedef logic [11:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;

	////////////////////////////////////////////////////////////
	// register map
	////////////////////////////////////////////////////////////

	localparam axil_addr_t REG_AP_CTRL  = 12'h000; // control / status
	localparam axil_addr_t REG_DATA_LEN = 12'h010; // samples per run
	localparam axil_addr_t REG_TAP_BASE = 12'h020; // tap 0 with one more tap every 4 bytes

	// bits of the control/status word
	localparam int AP_START_BIT = 0;
	localparam int AP_DONE_BIT  = 1;
	localparam int AP_IDLE_BIT  = 2;

endpackage

//--- fir_dsp_pkg.sv
package fir_dsp_pkg;

	////////////////////////////////////////////////////////////
	// filter shape
	////////////////////////////////////////////////////////////

	localparam int TAP_NUM = 11;

	////////////////////////////////////////////////////////////
	// datapath types
	////////////////////////////////////////////////////////////

	// samples, taps, products and sums all wrap at 32 bits
	typedef logic signed [31:0] sample_t;

	// index into tap ram or history ram
	typedef logic [3:0] tap_idx_t;

	// run length and result count
	typedef logic [31:0] len_t;

endpackage

//--- fir_bram.sv
`timescale 1ns/1ps

module fir_bram
	import fir_dsp_pkg::*;
#(
	parameter int DEPTH = TAP_NUM
) (
	input  logic     axis_clk,
	input  logic     axis_rst_n,
	input  logic     we,
	input  tap_idx_t wr_idx,
	input  sample_t  wr_data,
	input  tap_idx_t rd_idx,
	output sample_t  rd_data
);

	sample_t mem [DEPTH];

	// one write port, one read port, read data one cycle later
	always_ff @(posedge axis_clk) begin
		if (we) begin
			mem[wr_idx] <= wr_data;
		end
		rd_data <= mem[rd_idx]; // no bypass of a same-cycle write
	end

	// writers must keep their index inside the array
	a_wr_in_range: assert property (
		@(posedge axis_clk) disable iff (!axis_rst_n)
		we |-> (int'(wr_idx) < DEPTH)
	);

endmodule

//--- fir_axil_regs.sv
`timescale 1ns/1ps

module fir_axil_regs
	import fir_ctrl_pkg::*, fir_dsp_pkg::*;
(
	input  logic       axis_clk,
	input  logic       axis_rst_n,
	input  logic       awvalid,
	input  axil_addr_t awaddr,
	output logic       awready,
	input  logic       wvalid,
	input  axil_data_t wdata,
	output logic       wready,
	input  logic       arvalid,
	input  axil_addr_t araddr,
	output logic       arready,
	output logic       rvalid,
	input  logic       rready,
	output axil_data_t rdata,
	output logic       start_pulse,
	output len_t       data_len,
	input  logic       done_pulse,
	input  tap_idx_t   tap_rd_idx,
	output sample_t    tap_rd_data
);

	logic       aw_ack;
	logic       wr_fire;
	logic       ap_idle;
	logic       ap_done;
	logic       busy;
	axil_addr_t rd_addr_q;
	logic       tap_we;
	tap_idx_t   tap_ram_rd_idx;
	axil_data_t status;

	function automatic logic is_tap(axil_addr_t a);
		return (a >= REG_TAP_BASE) && (a < REG_TAP_BASE + axil_addr_t'(4 * TAP_NUM));
	endfunction

	function automatic tap_idx_t tap_of(axil_addr_t a);
		axil_addr_t ofs;
		ofs = a - REG_TAP_BASE;
		return ofs[5:2]; // word index
	endfunction

	////////////////////////////////////////////////////////////
	// write channel
	////////////////////////////////////////////////////////////

	always_ff @(posedge axis_clk) begin
		if (!axis_rst_n) begin
			aw_ack <= 1'b0;
		end else begin
			aw_ack <= awvalid && wvalid && !aw_ack; // single-cycle ack
		end
	end

	assign awready = aw_ack;
	assign wready  = aw_ack;
	assign wr_fire = aw_ack && awvalid && wvalid;

	// run control, done/idle state, data length
	always_ff @(posedge axis_clk) begin
		if (!axis_rst_n) begin
			start_pulse <= 1'b0;
			ap_idle     <= 1'b1;
			ap_done     <= 1'b0;
			busy        <= 1'b0;
			data_len    <= '0;
		end else begin
			start_pulse <= 1'b0;
			if (wr_fire && ap_idle) begin
				if (awaddr == REG_AP_CTRL && wdata[AP_START_BIT]) begin
					start_pulse <= 1'b1;
					ap_idle     <= 1'b0;
					ap_done     <= 1'b0;
				end
				if (awaddr == REG_DATA_LEN) begin
					data_len <= len_t'(wdata);
				end
			end
			if (start_pulse) begin
				busy <= 1'b1;
			end
			if (done_pulse) begin
				busy    <= 1'b0;
				ap_idle <= 1'b1;
				ap_done <= 1'b1;
			end else if (rvalid && rready && rd_addr_q == REG_AP_CTRL) begin
				ap_done <= 1'b0; // cleared by status read
			end
		end
	end

	////////////////////////////////////////////////////////////
	// read channel
	////////////////////////////////////////////////////////////

	always_comb begin
		status               = '0;
		status[AP_START_BIT] = busy;
		status[AP_DONE_BIT]  = ap_done;
		status[AP_IDLE_BIT]  = ap_idle;
	end

	always_ff @(posedge axis_clk) begin
		if (!axis_rst_n) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (arready) begin
				rvalid <= 1'b1;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// address caught with arvalid, data caught with arready
	always_ff @(posedge axis_clk) begin
		if (arvalid && !arready && !rvalid) begin
			rd_addr_q <= araddr;
		end
		if (arready) begin
			if (rd_addr_q == REG_AP_CTRL) begin
				rdata <= status;
			end else if (rd_addr_q == REG_DATA_LEN) begin
				rdata <= axil_data_t'(data_len);
			end else if (is_tap(rd_addr_q) && ap_idle) begin
				rdata <= axil_data_t'(tap_rd_data);
			end else begin
				rdata <= '0; // unmapped, or tap while running
			end
		end
	end

	////////////////////////////////////////////////////////////
	// tap ram with its read port handed to the engine while busy
	////////////////////////////////////////////////////////////

	assign tap_we         = wr_fire && ap_idle && is_tap(awaddr);
	assign tap_ram_rd_idx = busy ? tap_rd_idx : tap_of(araddr);

	fir_bram #(
		.DEPTH(TAP_NUM)
	) u_tap_ram (
		.axis_clk  (axis_clk),
		.axis_rst_n(axis_rst_n),
		.we        (tap_we),
		.wr_idx    (tap_of(awaddr)),
		.wr_data   (sample_t'(wdata)),
		.rd_idx    (tap_ram_rd_idx),
		.rd_data   (tap_rd_data)
	);

	// a run is never restarted underneath the engine
	a_start_idle: assert property (
		@(posedge axis_clk) disable iff (!axis_rst_n)
		start_pulse |-> !busy
	);

	// last output handshake only happens inside a run
	a_done_busy: assert property (
		@(posedge axis_clk) disable iff (!axis_rst_n)
		done_pulse |-> busy
	);

endmodule

//--- fir_mac_engine.sv
`timescale 1ns/1ps

module fir_mac_engine
	import fir_dsp_pkg::*;
(
	input  logic     axis_clk,
	input  logic     axis_rst_n,
	input  logic     start_pulse,
	input  len_t     data_len,
	input  logic     ss_tvalid,
	input  sample_t  ss_tdata,
	output logic     ss_tready,
	output tap_idx_t tap_rd_idx,
	input  sample_t  tap_rd_data,
	output logic     y_valid,
	output sample_t  y_data,
	input  logic     y_taken
);

	enum logic [2:0] {
		S_IDLE,
		S_CLEAR, // zero the history
		S_WAIT,  // waiting for a sample
		S_ACC,   // tap reads and mac
		S_HOLD   // result waiting for output stage
	} state;

	tap_idx_t cnt;    // clear index or tap index
	tap_idx_t wr_ptr; // slot of newest sample
	len_t     n_in;
	logic     rd_issue;
	logic     mac_en;
	sample_t  acc;
	logic     hist_we;
	tap_idx_t hist_wr_idx;
	sample_t  hist_wr_data;
	tap_idx_t hist_rd_idx;
	sample_t  hist_rd_data;

	assign ss_tready = (state == S_WAIT) && ss_tvalid;
	assign rd_issue  = (state == S_ACC) && (cnt < TAP_NUM);

	////////////////////////////////////////////////////////////
	// history ram ports
	////////////////////////////////////////////////////////////

	always_comb begin
		hist_we      = 1'b0;
		hist_wr_idx  = wr_ptr;
		hist_wr_data = ss_tdata;
		if (state == S_CLEAR) begin
			hist_we      = 1'b1;
			hist_wr_idx  = cnt;
			hist_wr_data = '0;
		end else if (ss_tready) begin
			hist_we = 1'b1; // new sample into its slot
		end
	end

	// sample i back sits at wr_ptr - i, wrapped
	assign hist_rd_idx = (wr_ptr >= cnt) ? tap_idx_t'(wr_ptr - cnt)
	                                     : tap_idx_t'(wr_ptr + TAP_NUM - cnt);
	assign tap_rd_idx  = rd_issue ? cnt : '0;

	fir_bram #(
		.DEPTH(TAP_NUM)
	) u_hist_ram (
		.axis_clk  (axis_clk),
		.axis_rst_n(axis_rst_n),
		.we        (hist_we),
		.wr_idx    (hist_wr_idx),
		.wr_data   (hist_wr_data),
		.rd_idx    (hist_rd_idx),
		.rd_data   (hist_rd_data)
	);

	////////////////////////////////////////////////////////////
	// sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge axis_clk) begin
		if (!axis_rst_n) begin
			state  <= S_IDLE;
			cnt    <= '0;
			wr_ptr <= '0;
			n_in   <= '0;
			mac_en <= 1'b0;
		end else begin
			mac_en <= rd_issue; // ram data arrives next cycle
			case (state)
				S_IDLE: begin
					if (start_pulse) begin
						state  <= S_CLEAR;
						cnt    <= '0;
						wr_ptr <= '0;
						n_in   <= '0;
					end
				end
				S_CLEAR: begin
					if (cnt == TAP_NUM - 1) begin
						cnt   <= '0;
						state <= S_WAIT;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				S_WAIT: begin
					if (ss_tready) begin
						n_in  <= n_in + 1'b1;
						cnt   <= '0;
						state <= S_ACC;
					end
				end
				S_ACC: begin
					// one extra cycle drains the last product
					if (cnt == TAP_NUM) begin
						state  <= S_HOLD;
						wr_ptr <= (wr_ptr == TAP_NUM - 1) ? '0 : wr_ptr + 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				S_HOLD: begin
					if (y_taken) begin
						state <= (n_in == data_len) ? S_IDLE : S_WAIT;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// wrapping accumulator
	always_ff @(posedge axis_clk) begin
		if (ss_tready) begin
			acc <= '0;
		end else if (mac_en) begin
			acc <= acc + tap_rd_data * hist_rd_data;
		end
	end

	assign y_valid = (state == S_HOLD);
	assign y_data  = acc;

endmodule

//--- fir_stream_out.sv
`timescale 1ns/1ps

module fir_stream_out
	import fir_dsp_pkg::*;
(
	input  logic    axis_clk,
	input  logic    axis_rst_n,
	input  logic    y_valid,
	input  sample_t y_data,
	input  len_t    data_len,
	input  logic    start_pulse,
	output logic    y_taken,
	input  logic    sm_tready,
	output logic    sm_tvalid,
	output sample_t sm_tdata,
	output logic    sm_tlast,
	output logic    done_pulse
);

	len_t out_cnt; // results loaded this run
	logic last_next;

	// register free, or emptied this cycle
	assign y_taken    = y_valid && (!sm_tvalid || sm_tready);
	assign last_next  = (out_cnt + 1'b1 == data_len);
	assign done_pulse = sm_tvalid && sm_tready && sm_tlast;

	always_ff @(posedge axis_clk) begin
		if (!axis_rst_n) begin
			sm_tvalid <= 1'b0;
			sm_tlast  <= 1'b0;
			out_cnt   <= '0;
		end else begin
			if (start_pulse) begin
				out_cnt <= '0;
			end
			if (y_taken) begin
				sm_tvalid <= 1'b1;
				sm_tlast  <= last_next;
				out_cnt   <= out_cnt + 1'b1;
			end else if (sm_tready) begin
				sm_tvalid <= 1'b0;
				sm_tlast  <= 1'b0;
			end
		end
	end

	always_ff @(posedge axis_clk) begin
		if (y_taken) begin
			sm_tdata <= y_data;
		end
	end

	// stalled beat must not move
	a_hold_stable: assert property (
		@(posedge axis_clk) disable iff (!axis_rst_n)
		sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast)
	);

endmodule

//--- fir_top.sv
`timescale 1ns/1ps

module fir_top
	import fir_ctrl_pkg::*, fir_dsp_pkg::*;
(
	input  logic       axis_clk,
	input  logic       axis_rst_n,
	// axi-lite
	input  logic       awvalid,
	input  axil_addr_t awaddr,
	output logic       awready,
	input  logic       wvalid,
	input  axil_data_t wdata,
	output logic       wready,
	input  logic       arvalid,
	input  axil_addr_t araddr,
	output logic       arready,
	output logic       rvalid,
	input  logic       rready,
	output axil_data_t rdata,
	// stream in
	input  logic       ss_tvalid,
	input  sample_t    ss_tdata,
	input  logic       ss_tlast,  // end of run comes from data_len
	output logic       ss_tready,
	// stream out
	input  logic       sm_tready,
	output logic       sm_tvalid,
	output sample_t    sm_tdata,
	output logic       sm_tlast
);

	logic     start_pulse;
	len_t     data_len;
	logic     done_pulse;
	tap_idx_t tap_rd_idx;
	sample_t  tap_rd_data;
	logic     y_valid;
	sample_t  y_data;
	logic     y_taken;

	fir_axil_regs u_regs (
		.axis_clk   (axis_clk),
		.axis_rst_n (axis_rst_n),
		.awvalid    (awvalid),
		.awaddr     (awaddr),
		.awready    (awready),
		.wvalid     (wvalid),
		.wdata      (wdata),
		.wready     (wready),
		.arvalid    (arvalid),
		.araddr     (araddr),
		.arready    (arready),
		.rvalid     (rvalid),
		.rready     (rready),
		.rdata      (rdata),
		.start_pulse(start_pulse),
		.data_len   (data_len),
		.done_pulse (done_pulse),
		.tap_rd_idx (tap_rd_idx),
		.tap_rd_data(tap_rd_data)
	);

	fir_mac_engine u_engine (
		.axis_clk   (axis_clk),
		.axis_rst_n (axis_rst_n),
		.start_pulse(start_pulse),
		.data_len   (data_len),
		.ss_tvalid  (ss_tvalid),
		.ss_tdata   (ss_tdata),
		.ss_tready  (ss_tready),
		.tap_rd_idx (tap_rd_idx),
		.tap_rd_data(tap_rd_data),
		.y_valid    (y_valid),
		.y_data     (y_data),
		.y_taken    (y_taken)
	);

	fir_stream_out u_out (
		.axis_clk   (axis_clk),
		.axis_rst_n (axis_rst_n),
		.y_valid    (y_valid),
		.y_data     (y_data),
		.data_len   (data_len),
		.start_pulse(start_pulse),
		.y_taken    (y_taken),
		.sm_tready  (sm_tready),
		.sm_tvalid  (sm_tvalid),
		.sm_tdata   (sm_tdata),
		.sm_tlast   (sm_tlast),
		.done_pulse (done_pulse)
	);

endmodule

//--- tb_fir_tasks.svh
`ifndef TB_FIR_TASKS_SVH
`define TB_FIR_TASKS_SVH

////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////

task automatic check_word(input string name, input axil_data_t exp, input axil_data_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("MISMATCH %s: expected %h, actual %h", name, exp, act);
	end
endtask

task automatic check_sample(input string name, input sample_t exp, input sample_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("MISMATCH %s: expected %h, actual %h", name, exp, act);
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("MISMATCH %s: expected %b, actual %b", name, exp, act);
	end
endtask

////////////////////////////////////////////////////////////
// bus drivers
////////////////////////////////////////////////////////////

task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
	@(posedge axis_clk);
	#1;
	awvalid = 1'b1;
	awaddr  = addr;
	wvalid  = 1'b1;
	wdata   = data;
	do begin
		@(negedge axis_clk);
	end while (!(awready && wready)); // handshake on the next edge
	@(posedge axis_clk);
	#1;
	awvalid = 1'b0;
	wvalid  = 1'b0;
endtask

task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
	@(posedge axis_clk);
	#1;
	arvalid = 1'b1;
	araddr  = addr;
	rready  = 1'b1;
	do begin
		@(negedge axis_clk);
	end while (!arready);
	@(posedge axis_clk);
	#1;
	arvalid = 1'b0;
	do begin
		@(negedge axis_clk);
	end while (!rvalid);
	data = rdata;
	@(posedge axis_clk);
	#1;
	rready = 1'b0;
endtask

task automatic stream_send(input sample_t d);
	@(posedge axis_clk);
	#1;
	ss_tvalid = 1'b1;
	ss_tdata  = d;
	do begin
		@(negedge axis_clk);
	end while (!ss_tready);
	@(posedge axis_clk);
	#1;
	ss_tvalid = 1'b0;
endtask

// returns at the negedge before the accepting edge
task automatic stream_recv(input bit stall, output sample_t d, output logic last);
	logic got;
	got = 1'b0;
	while (!got) begin
		@(posedge axis_clk);
		#1;
		sm_tready = stall ? logic'($urandom % 2) : 1'b1;
		@(negedge axis_clk);
		if (sm_tvalid && sm_tready) begin
			d    = sm_tdata;
			last = sm_tlast;
			got  = 1'b1;
		end
	end
endtask

////////////////////////////////////////////////////////////
// run helpers
////////////////////////////////////////////////////////////

task automatic write_random_taps();
	for (int i = 0; i < TAP_NUM; i++) begin
		taps[i] = sample_t'($urandom);
		axil_write(REG_TAP_BASE + axil_addr_t'(4 * i), axil_data_t'(taps[i]));
	end
endtask

task automatic readback_taps(input string name);
	axil_data_t word;
	for (int i = 0; i < TAP_NUM; i++) begin
		axil_read(REG_TAP_BASE + axil_addr_t'(4 * i), word);
		check_word($sformatf("%s tap %0d", name, i), axil_data_t'(taps[i]), word);
	end
endtask

task automatic fill_random(input int n);
	xs.delete();
	repeat (n) xs.push_back(sample_t'($urandom));
endtask

// one whole run over xs with an optional tap write mid-run
task automatic run_filter(input string name, input bit stall, input bit poke);
	sample_t got_data;
	logic    got_last;
	int      n;
	n = xs.size();
	build_expected();
	axil_write(REG_DATA_LEN, axil_data_t'(n));
	axil_write(REG_AP_CTRL, axil_data_t'(1) << AP_START_BIT);
	fork
		begin
			for (int k = 0; k < n; k++) begin
				stream_send(xs[k]);
			end
		end
		begin
			for (int k = 0; k < n; k++) begin
				stream_recv(stall, got_data, got_last);
				check_sample($sformatf("%s y[%0d]", name, k), exp_q[k], got_data);
				check_bit($sformatf("%s tlast[%0d]", name, k), logic'(k == n - 1), got_last);
			end
		end
		begin
			if (poke) begin
				repeat (30) @(posedge axis_clk);
				axil_write(REG_TAP_BASE + axil_addr_t'(12), axil_data_t'(~taps[3]));
			end
		end
	join
	@(posedge axis_clk); // last beat accepted here
	#1;
	sm_tready = 1'b0;
	repeat (2 * TAP_NUM) @(negedge axis_clk);
	check_bit({name, " no result after tlast"}, 1'b0, sm_tvalid);
endtask

////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////

task automatic reset_and_tap_readback();
	axil_data_t word;
	// handshake outputs quiet out of reset
	check_bit("reset awready", 1'b0, awready);
	check_bit("reset wready", 1'b0, wready);
	check_bit("reset arready", 1'b0, arready);
	check_bit("reset rvalid", 1'b0, rvalid);
	check_bit("reset ss_tready", 1'b0, ss_tready);
	check_bit("reset sm_tvalid", 1'b0, sm_tvalid);
	check_bit("reset sm_tlast", 1'b0, sm_tlast);
	axil_read(REG_AP_CTRL, word);
	check_word("reset status", axil_data_t'(1) << AP_IDLE_BIT, word);
	write_random_taps();
	readback_taps("tap readback");
endtask

// impulse in, taps out in order
task automatic impulse_response();
	xs.delete();
	xs.push_back(sample_t'(1));
	repeat (TAP_NUM - 1) xs.push_back('0);
	run_filter("impulse", 1'b0, 1'b0);
endtask

task automatic random_run_status();
	axil_data_t word;
	axil_data_t idle_word;
	idle_word = axil_data_t'(1) << AP_IDLE_BIT;
	fill_random(40);
	run_filter("random run", 1'b0, 1'b0);
	axil_read(REG_AP_CTRL, word);
	check_word("status after run", idle_word | (axil_data_t'(1) << AP_DONE_BIT), word);
	axil_read(REG_AP_CTRL, word);
	check_word("status reread", idle_word, word); // done cleared by first read
endtask

task automatic stalled_output_run();
	fill_random(30);
	run_filter("stalled run", 1'b1, 1'b0);
endtask

// new taps on a history that starts from zero again
task automatic second_run_fresh_history();
	write_random_taps();
	fill_random(20);
	run_filter("second run", 1'b0, 1'b1);
	readback_taps("taps after busy write");
endtask

`endif

//--- tb_fir.sv
`timescale 1ns/1ps

module tb_fir
	import fir_ctrl_pkg::*, fir_dsp_pkg::*;
();

	localparam logic [31:0] SEED = 32'hbc30_4cb0;

	// samples of the impulse, random, stalled and second runs
	localparam int TOTAL_SAMPLES = 11 + 40 + 30 + 20;
	localparam int CYCLE_LIMIT   = 40 * TOTAL_SAMPLES + 2000;

	logic       axis_clk;
	logic       axis_rst_n;
	logic       awvalid;
	axil_addr_t awaddr;
	logic       awready;
	logic       wvalid;
	axil_data_t wdata;
	logic       wready;
	logic       arvalid;
	axil_addr_t araddr;
	logic       arready;
	logic       rvalid;
	logic       rready;
	axil_data_t rdata;
	logic       ss_tvalid;
	sample_t    ss_tdata;
	logic       ss_tlast;
	logic       ss_tready;
	logic       sm_tready;
	logic       sm_tvalid;
	sample_t    sm_tdata;
	logic       sm_tlast;

	sample_t taps [TAP_NUM]; // taps as the filter should hold them
	sample_t xs [$];         // samples of the current run
	sample_t exp_q [$];      // expected results of the current run
	int      errors = 0;
	int      checks = 0;
	int      cycles = 0;

	fir_top uut (
		.axis_clk  (axis_clk),
		.axis_rst_n(axis_rst_n),
		.awvalid   (awvalid),
		.awaddr    (awaddr),
		.awready   (awready),
		.wvalid    (wvalid),
		.wdata     (wdata),
		.wready    (wready),
		.arvalid   (arvalid),
		.araddr    (araddr),
		.arready   (arready),
		.rvalid    (rvalid),
		.rready    (rready),
		.rdata     (rdata),
		.ss_tvalid (ss_tvalid),
		.ss_tdata  (ss_tdata),
		.ss_tlast  (ss_tlast),
		.ss_tready (ss_tready),
		.sm_tready (sm_tready),
		.sm_tvalid (sm_tvalid),
		.sm_tdata  (sm_tdata),
		.sm_tlast  (sm_tlast)
	);

	always #5 axis_clk = ~axis_clk;

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// y[n] = sum of taps[i] * x[n-i] over a history that starts at zero
	function automatic void build_expected();
		sample_t acc;
		exp_q.delete();
		for (int n = 0; n < xs.size(); n++) begin
			acc = '0;
			for (int i = 0; i < TAP_NUM && i <= n; i++) begin
				acc = acc + taps[i] * xs[n - i]; // 32-bit wrap
			end
			exp_q.push_back(acc);
		end
	endfunction

	`include "tb_fir_tasks.svh"

	// run limit
	always @(posedge axis_clk) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
			$display("checks: %0d, errors: %0d", checks, errors + 1);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		void'($urandom(SEED));
		axis_clk   = 1'b0;
		axis_rst_n = 1'b0;
		awvalid    = 1'b0;
		awaddr     = '0;
		wvalid     = 1'b0;
		wdata      = '0;
		arvalid    = 1'b0;
		araddr     = '0;
		rready     = 1'b0;
		ss_tvalid  = 1'b0;
		ss_tdata   = '0;
		ss_tlast   = 1'b0; // unused by the filter
		sm_tready  = 1'b0;
		repeat (2) @(posedge axis_clk);
		#1;
		axis_rst_n = 1'b1;

		reset_and_tap_readback();
		impulse_response();
		random_run_status();
		stalled_output_run();
		second_run_fresh_history();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- tb.f
+incdir+.
fir_ctrl_pkg.sv
fir_dsp_pkg.sv
fir_bram.sv
fir_axil_regs.sv
fir_mac_engine.sv
fir_stream_out.sv
fir_top.sv
tb_fir.sv

//--- Bender.yml
package:
  name: fir_axis

sources:
  - files:
      - fir_ctrl_pkg.sv
      - fir_dsp_pkg.sv
      - fir_bram.sv
      - fir_axil_regs.sv
      - fir_mac_engine.sv
      - fir_stream_out.sv
      - fir_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fir.sv
